// File: rtl/vertex_control_cfg.svh
`ifndef VERTEX_CONTROL_CFG_SVH
`define VERTEX_CONTROL_CFG_SVH

// vertices per cache line as a power of two
`define VC_LINE_WORDS 8

// bytes per bus word and per vertex field
`define VC_WORD_BYTES 4
`define VC_WORD_W (`VC_WORD_BYTES * 8)

// wishbone byte address
`define VC_ADDR_W 32

// one full line fits in the job fifo
`define VC_FIFO_DEPTH `VC_LINE_WORDS

// in-degree, out-degree and edge index fetchers
`define VC_NUM_FETCH 3

`endif

// File: rtl/vertex_control_pkg.sv
`include "vertex_control_cfg.svh"

package vertex_control_pkg;

	////////////////////////////////////////
	// vertex record handed to the consumer
	////////////////////////////////////////
	typedef struct packed {
		logic [`VC_WORD_W-1:0] id;
		logic [`VC_WORD_W-1:0] in_degree;
		logic [`VC_WORD_W-1:0] out_degree;
		logic [`VC_WORD_W-1:0] edges_idx;	// first edge of this vertex
	} vertex_t;

	////////////////////////////////////////
	// bus word seen whole or per byte
	////////////////////////////////////////
	typedef union packed {
		logic [`VC_WORD_W-1:0] value;
		logic [`VC_WORD_BYTES-1:0][7:0] bytes;	// bytes[0] is the low byte
	} wb_word_u;

endpackage

// File: rtl/vertex_line_fetch.sv
`include "vertex_control_cfg.svh"

module vertex_line_fetch (
	input  logic clock,
	input  logic rstn,
	input  logic line_start,
	input  logic [`VC_ADDR_W-1:0] line_offset,
	input  logic [`VC_ADDR_W-1:0] base_addr,
	input  logic wb_ack,
	input  vertex_control_pkg::wb_word_u wb_dat_i,
	output logic wb_cyc,
	output logic wb_stb,
	output logic [`VC_ADDR_W-1:0] wb_adr,
	output logic line_ready,
	output logic [`VC_LINE_WORDS-1:0][`VC_WORD_W-1:0] line_data
);

	localparam int CNT_W = $clog2(`VC_LINE_WORDS);
	localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`VC_LINE_WORDS - 1);
	localparam logic [`VC_ADDR_W-1:0] WORD_STEP = `VC_WORD_BYTES;

	logic [CNT_W-1:0] word_cnt;
	logic [`VC_ADDR_W-1:0] addr;
	logic take;
	vertex_control_pkg::wb_word_u swapped;

	assign take = wb_cyc && wb_stb && wb_ack;
	assign wb_adr = addr;

	// memory is big-endian
	always_comb begin
		for (int i = 0; i < `VC_WORD_BYTES; i++) begin
			swapped.bytes[i] = wb_dat_i.bytes[`VC_WORD_BYTES-1-i];
		end
	end

	////////////////////////////////////////
	// classic read cycles with cyc held per line
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wb_cyc     <= 1'b0;
			wb_stb     <= 1'b0;
			line_ready <= 1'b0;
			word_cnt   <= '0;
		end else if (line_start) begin
			wb_cyc     <= 1'b1;
			wb_stb     <= 1'b1;
			line_ready <= 1'b0;
			word_cnt   <= '0;
		end else if (wb_cyc) begin
			if (take) begin
				wb_stb   <= 1'b0;	// idle cycle before next word
				word_cnt <= word_cnt + 1'b1;
				if (word_cnt == LAST_WORD) begin
					wb_cyc     <= 1'b0;
					line_ready <= 1'b1;
				end
			end else begin
				wb_stb <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (line_start) begin
			addr <= base_addr + line_offset;
		end else if (take) begin
			addr <= addr + WORD_STEP;
		end
		if (take) begin
			line_data[word_cnt] <= swapped.value;
		end
	end

endmodule

// File: rtl/wb_read_arbiter.sv
`include "vertex_control_cfg.svh"

module wb_read_arbiter (
	input  logic clock,
	input  logic rstn,
	input  logic [`VC_NUM_FETCH-1:0] req_cyc,
	input  logic [`VC_NUM_FETCH-1:0] req_stb,
	input  logic [`VC_NUM_FETCH-1:0][`VC_ADDR_W-1:0] req_adr,
	input  logic wb_ack,
	output logic [`VC_NUM_FETCH-1:0] req_ack,
	output logic wb_cyc,
	output logic wb_stb,
	output logic [`VC_ADDR_W-1:0] wb_adr
);

	localparam int IDX_W = $clog2(`VC_NUM_FETCH);

	logic grant_valid;
	logic [IDX_W-1:0] grant_idx;
	logic [IDX_W-1:0] last;	// previous winner
	logic pick_found;
	logic [IDX_W-1:0] pick_idx;
	logic release_grant;

	// search starts just after the last winner
	always_comb begin
		int cand;
		pick_found = 1'b0;
		pick_idx   = last;
		for (int k = 1; k <= `VC_NUM_FETCH; k++) begin
			cand = (int'(last) + k) % `VC_NUM_FETCH;
			if (!pick_found && req_cyc[cand]) begin
				pick_found = 1'b1;
				pick_idx   = IDX_W'(cand);
			end
		end
	end

	assign release_grant = !grant_valid || !req_cyc[grant_idx];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_valid <= 1'b0;
			grant_idx   <= '0;
			last        <= IDX_W'(`VC_NUM_FETCH - 1);	// fetcher 0 goes first
		end else if (release_grant) begin
			grant_valid <= pick_found;
			if (pick_found) begin
				grant_idx <= pick_idx;
				last      <= pick_idx;
			end
		end
	end

	////////////////////////////////////////
	// shared bus mux
	////////////////////////////////////////
	assign wb_cyc = grant_valid && req_cyc[grant_idx];
	assign wb_stb = grant_valid && req_stb[grant_idx];
	assign wb_adr = req_adr[grant_idx];

	always_comb begin
		req_ack = '0;
		req_ack[grant_idx] = grant_valid && wb_ack;	// only the owner sees ack
	end

endmodule

// File: rtl/vertex_sequencer.sv
`include "vertex_control_cfg.svh"

module vertex_sequencer (
	input  logic clock,
	input  logic rstn,
	input  logic start,
	input  logic [`VC_WORD_W-1:0] num_vertices,
	input  logic [`VC_LINE_WORDS-1:0][`VC_WORD_W-1:0] in_degree_line,
	input  logic [`VC_LINE_WORDS-1:0][`VC_WORD_W-1:0] out_degree_line,
	input  logic [`VC_LINE_WORDS-1:0][`VC_WORD_W-1:0] edges_idx_line,
	input  logic [`VC_NUM_FETCH-1:0] lines_ready,
	input  logic fifo_empty,
	output logic line_start,
	output logic [`VC_ADDR_W-1:0] line_offset,
	output logic push,
	output vertex_control_pkg::vertex_t push_vertex,
	output logic busy
);

	localparam int IDX_W = $clog2(`VC_LINE_WORDS);
	localparam int SIZE_W = IDX_W + 1;
	localparam logic [`VC_WORD_W-1:0] LINE_VERTS = `VC_LINE_WORDS;
	localparam logic [SIZE_W-1:0] FULL_SIZE = `VC_LINE_WORDS;
	localparam logic [`VC_ADDR_W-1:0] LINE_BYTES = `VC_LINE_WORDS * `VC_WORD_BYTES;

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_REQ = 3'd1;
	localparam logic [2:0] S_WAIT = 3'd2;
	localparam logic [2:0] S_UNPACK = 3'd3;
	localparam logic [2:0] S_WAIT_EMPTY = 3'd4;

	logic [2:0] state;
	logic [`VC_WORD_W-1:0] remaining;	// vertices not yet requested
	logic [`VC_WORD_W-1:0] next_id;
	logic [SIZE_W-1:0] real_size;
	logic [IDX_W-1:0] unpack_idx;
	logic last_word;

	assign busy = state != S_IDLE;
	assign last_word = {1'b0, unpack_idx} == real_size - 1'b1;

	////////////////////////////////////////
	// line sequencing
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= S_IDLE;
			remaining   <= '0;
			next_id     <= '0;
			line_offset <= '0;
			real_size   <= '0;
			unpack_idx  <= '0;
			line_start  <= 1'b0;
		end else begin
			line_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						remaining   <= num_vertices;
						next_id     <= '0;
						line_offset <= '0;
						state       <= S_REQ;
					end
				end
				S_REQ: begin
					if (remaining == '0) begin
						state <= S_WAIT_EMPTY;
					end else if (fifo_empty) begin	// whole line must fit
						if (remaining >= LINE_VERTS) begin
							real_size <= FULL_SIZE;
							remaining <= remaining - LINE_VERTS;
						end else begin
							real_size <= remaining[SIZE_W-1:0];	// tail line
							remaining <= '0;
						end
						line_start <= 1'b1;
						state      <= S_WAIT;
					end
				end
				S_WAIT: begin
					// ready flags still show the old line while line_start is high
					if (!line_start && &lines_ready) begin
						unpack_idx <= '0;
						state      <= S_UNPACK;
					end
				end
				S_UNPACK: begin
					next_id    <= next_id + 1'b1;	// dropped vertices keep their id
					unpack_idx <= unpack_idx + 1'b1;
					if (last_word) begin
						line_offset <= line_offset + LINE_BYTES;
						state       <= (remaining == '0) ? S_WAIT_EMPTY : S_REQ;
					end
				end
				S_WAIT_EMPTY: begin
					if (fifo_empty) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// unpack and zero-degree filter
	////////////////////////////////////////
	always_comb begin
		push_vertex.id         = next_id;
		push_vertex.in_degree  = in_degree_line[unpack_idx];
		push_vertex.out_degree = out_degree_line[unpack_idx];
		push_vertex.edges_idx  = edges_idx_line[unpack_idx];
	end

	assign push = (state == S_UNPACK) &&
		((|push_vertex.in_degree) || (|push_vertex.out_degree));

endmodule

// File: rtl/vertex_job_fifo.sv
`include "vertex_control_cfg.svh"

module vertex_job_fifo (
	input  logic clock,
	input  logic rstn,
	input  logic push,
	input  vertex_control_pkg::vertex_t push_vertex,
	input  logic pop,
	output vertex_control_pkg::vertex_t vertex,
	output logic vertex_valid,
	output logic empty
);

	localparam int PTR_W = $clog2(`VC_FIFO_DEPTH);
	localparam logic [PTR_W:0] DEPTH = `VC_FIFO_DEPTH;

	vertex_control_pkg::vertex_t mem [`VC_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && (count != DEPTH);
	assign do_pop = pop && vertex_valid;

	// head is always on the output
	assign vertex = mem[rd_ptr];
	assign vertex_valid = count != '0;
	assign empty = count == '0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;	// depth is a power of two
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_vertex;
		end
	end

endmodule

// File: rtl/vertex_control_top.sv
`include "vertex_control_cfg.svh"

module vertex_control_top (
	input  logic clock,
	input  logic rstn,
	input  logic start,
	input  logic [`VC_WORD_W-1:0] num_vertices,
	input  logic [`VC_ADDR_W-1:0] in_degree_base,
	input  logic [`VC_ADDR_W-1:0] out_degree_base,
	input  logic [`VC_ADDR_W-1:0] edges_idx_base,
	input  logic vertex_pop,
	input  vertex_control_pkg::wb_word_u wb_dat_i,
	input  logic wb_ack,
	output logic wb_cyc,
	output logic wb_stb,
	output logic [`VC_ADDR_W-1:0] wb_adr,
	output logic wb_we,
	output vertex_control_pkg::vertex_t vertex,
	output logic vertex_valid,
	output logic busy
);

	logic [`VC_NUM_FETCH-1:0][`VC_ADDR_W-1:0] fetch_base;
	logic [`VC_NUM_FETCH-1:0] fetch_cyc;
	logic [`VC_NUM_FETCH-1:0] fetch_stb;
	logic [`VC_NUM_FETCH-1:0][`VC_ADDR_W-1:0] fetch_adr;
	logic [`VC_NUM_FETCH-1:0] fetch_ack;
	logic [`VC_NUM_FETCH-1:0] fetch_ready;
	logic [`VC_NUM_FETCH-1:0][`VC_LINE_WORDS-1:0][`VC_WORD_W-1:0] fetch_line;
	logic line_start;
	logic [`VC_ADDR_W-1:0] line_offset;
	logic push;
	vertex_control_pkg::vertex_t push_vertex;
	logic fifo_empty;

	assign wb_we = 1'b0;	// read-only master
	// 0 in-degree, 1 out-degree, 2 edge index
	assign fetch_base = {edges_idx_base, out_degree_base, in_degree_base};

	////////////////////////////////////////
	// array fetchers on the shared bus
	////////////////////////////////////////
	for (genvar i = 0; i < `VC_NUM_FETCH; i++) begin : g_fetch
		vertex_line_fetch vertex_line_fetch_inst (
			.clock(clock),
			.rstn(rstn),
			.line_start(line_start),
			.line_offset(line_offset),
			.base_addr(fetch_base[i]),
			.wb_ack(fetch_ack[i]),
			.wb_dat_i(wb_dat_i),
			.wb_cyc(fetch_cyc[i]),
			.wb_stb(fetch_stb[i]),
			.wb_adr(fetch_adr[i]),
			.line_ready(fetch_ready[i]),
			.line_data(fetch_line[i])
		);
	end

	wb_read_arbiter wb_read_arbiter_inst (
		.clock(clock),
		.rstn(rstn),
		.req_cyc(fetch_cyc),
		.req_stb(fetch_stb),
		.req_adr(fetch_adr),
		.wb_ack(wb_ack),
		.req_ack(fetch_ack),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr)
	);

	vertex_sequencer vertex_sequencer_inst (
		.clock(clock),
		.rstn(rstn),
		.start(start),
		.num_vertices(num_vertices),
		.in_degree_line(fetch_line[0]),
		.out_degree_line(fetch_line[1]),
		.edges_idx_line(fetch_line[2]),
		.lines_ready(fetch_ready),
		.fifo_empty(fifo_empty),
		.line_start(line_start),
		.line_offset(line_offset),
		.push(push),
		.push_vertex(push_vertex),
		.busy(busy)
	);

	vertex_job_fifo vertex_job_fifo_inst (
		.clock(clock),
		.rstn(rstn),
		.push(push),
		.push_vertex(push_vertex),
		.pop(vertex_pop),
		.vertex(vertex),
		.vertex_valid(vertex_valid),
		.empty(fifo_empty)
	);

endmodule

// File: testbench/wb_mem_model.sv
`include "vertex_control_cfg.svh"

module wb_mem_model (
	input  logic clock,
	input  logic rstn,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic [`VC_ADDR_W-1:0] wb_adr,
	output logic [`VC_WORD_W-1:0] wb_dat_o,
	output logic wb_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_WORDS = 512;
	localparam int IDX_W = $clog2(MEM_WORDS);

	logic [`VC_WORD_W-1:0] mem [MEM_WORDS];	// big-endian words
	logic [1:0] wait_left;
	logic pending;
	integer seed;

	initial begin
		seed = 32'h5fdf_e666;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = 32'hbad0_0000 | 32'(i);	// words the image leaves out
		end
		$readmemh("testbench/vertex_control_golden.txt", mem);
	end

	////////////////////////////////////////
	// classic slave with random wait states
	////////////////////////////////////////
	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wb_ack    <= 1'b0;
			wb_dat_o  <= '0;
			pending   <= 1'b0;
			wait_left <= '0;
		end else begin
			wb_ack <= 1'b0;	// one cycle ack
			if (wb_cyc && wb_stb && !wb_ack) begin
				if (!pending) begin
					pending   <= 1'b1;
					wait_left <= 2'($random(seed));	// zero to three cycles
				end else if (wait_left != '0) begin
					wait_left <= wait_left - 1'b1;
				end else begin
					pending  <= 1'b0;
					wb_ack   <= 1'b1;
					wb_dat_o <= mem[wb_adr[IDX_W+1:2]];
				end
			end
		end
	end

endmodule

// File: testbench/vertex_control_tb.sv
`include "vertex_control_cfg.svh"

module vertex_control_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int GOLDEN_WORDS = 512;
	localparam int NUM_RUNS = 3;
	localparam int RUN_BASE = 'h100;	// eight words per run
	localparam int REC_BASE = 'h120;	// four words per record

	logic clock;
	logic rstn;
	logic start;
	logic [`VC_WORD_W-1:0] num_vertices;
	logic [`VC_ADDR_W-1:0] in_degree_base;
	logic [`VC_ADDR_W-1:0] out_degree_base;
	logic [`VC_ADDR_W-1:0] edges_idx_base;
	logic vertex_pop;
	vertex_control_pkg::wb_word_u wb_dat_i;
	logic wb_ack;
	logic wb_cyc;
	logic wb_stb;
	logic [`VC_ADDR_W-1:0] wb_adr;
	logic wb_we;
	vertex_control_pkg::vertex_t vertex;
	logic vertex_valid;
	logic busy;

	logic [`VC_WORD_W-1:0] golden [GOLDEN_WORDS];
	logic loaded;
	integer seed;

	vertex_control_top vertex_control_top_inst (
		.clock(clock),
		.rstn(rstn),
		.start(start),
		.num_vertices(num_vertices),
		.in_degree_base(in_degree_base),
		.out_degree_base(out_degree_base),
		.edges_idx_base(edges_idx_base),
		.vertex_pop(vertex_pop),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_we(wb_we),
		.vertex(vertex),
		.vertex_valid(vertex_valid),
		.busy(busy)
	);

	wb_mem_model wb_mem_model_inst (
		.clock(clock),
		.rstn(rstn),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat_o(wb_dat_i),
		.wb_ack(wb_ack)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// budget grows with the number of expected records
	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = 1000;
		for (int r = 0; r < NUM_RUNS; r++) begin
			limit += 200 * int'(golden[RUN_BASE + 8 * r + 5]);
		end
		repeat (limit) @(posedge clock);
		$display("timeout after %0d cycles, the DUT never finished its runs", limit);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic check_vertex(input string name, input vertex_control_pkg::vertex_t got,
			input vertex_control_pkg::vertex_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// one start request, then pop and compare every record
	task automatic run_case(input int run);
		int desc;
		int first;
		int count;
		int got;
		int rec;
		logic random_pop;
		vertex_control_pkg::vertex_t exp_v;
		desc = RUN_BASE + 8 * run;
		first = int'(golden[desc + 4]);
		count = int'(golden[desc + 5]);
		random_pop = golden[desc + 6] != '0;
		got = 0;
		@(posedge clock);
		start           <= 1'b1;
		num_vertices    <= golden[desc];
		in_degree_base  <= golden[desc + 1];
		out_degree_base <= golden[desc + 2];
		edges_idx_base  <= golden[desc + 3];
		@(posedge clock);
		start <= 1'b0;
		while (got < count) begin
			@(negedge clock);
			check_bit("busy", busy, 1'b1);	// records still owed
			if (vertex_valid && vertex_pop) begin	// head leaves on the next edge
				rec = REC_BASE + 4 * (first + got);
				exp_v.id         = golden[rec];
				exp_v.in_degree  = golden[rec + 1];
				exp_v.out_degree = golden[rec + 2];
				exp_v.edges_idx  = golden[rec + 3];
				check_vertex("vertex", vertex, exp_v);
				got++;
			end
			@(posedge clock);
			if (got < count) begin
				vertex_pop <= random_pop ? 1'($random(seed)) : 1'b1;
			end else begin
				vertex_pop <= 1'b0;
			end
		end
		@(negedge clock);
		while (busy) begin
			@(negedge clock);
		end
		check_bit("vertex_valid", vertex_valid, 1'b0);	// no record past the last
		check_bit("wb_cyc", wb_cyc, 1'b0);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		rstn            = 1'b0;
		start           = 1'b0;
		num_vertices    = '0;
		in_degree_base  = '0;
		out_degree_base = '0;
		edges_idx_base  = '0;
		vertex_pop      = 1'b0;
		seed            = 32'h5fdf_e666;
		loaded          = 1'b0;
		$readmemh("testbench/vertex_control_golden.txt", golden);
		loaded = 1'b1;
		repeat (5) @(posedge clock);
		rstn <= 1'b1;
		@(negedge clock);
		check_bit("vertex_valid", vertex_valid, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("wb_cyc", wb_cyc, 1'b0);
		check_bit("wb_stb", wb_stb, 1'b0);
		check_bit("wb_we", wb_we, 1'b0);
		for (int run = 0; run < NUM_RUNS; run++) begin
			run_case(run);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: vertex_control.f
+incdir+rtl
rtl/vertex_control_pkg.sv
rtl/vertex_line_fetch.sv
rtl/wb_read_arbiter.sv
rtl/vertex_sequencer.sv
rtl/vertex_job_fifo.sv
rtl/vertex_control_top.sv
testbench/wb_mem_model.sv
testbench/vertex_control_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= vertex_control_tb
FILELIST ?= vertex_control.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary -Wno-fatal
PASS_MSG ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/vertex_control_golden.txt
// memory image: big-endian words at word address (byte address / 4)
// @100 runs: vertices, in base, out base, edges base, first record, records, random pop, pad
// @120 expected records, native order: id, in degree, out degree, edges idx
// run a arrays: in degree, out degree, edges idx
@000 01000000 02000000 44332211 01000000 04000000
@008 02000000 00000000 01000000 05000000 01000000
@010 00000000 03000000 05000000 08000000 09010000
// run b in degree
@020 03000000 00000000 00000000 01000000 02000000 05000000 01000000 00000000
00000000 04000000 01000000 02000000 07000000 00000000 01000000 03000000
00000100 02000000 00000000
// run b out degree
@040 01000000 02000000 00000000 00000000 02000000 03000000 01000000 00000000
00000000 00010000 02000000 01000000 03000000 00000000 01000000 02000000
01000000 04000000 00000000
// run b edges idx
@060 00000000 03000000 05000000 05000000 06000000 08000000 0b000000 0c000000
0c000000 0c000000 10010000 12010000 13010000 16010000 16010000 17010000
19010000 1a010000 1e010000
// start requests
@100 00000005 00000000 00000020 00000040 00000000 00000005 00000000 00000000
@108 00000013 00000080 00000100 00000180 00000005 0000000e 00000000 00000000
@110 00000013 00000080 00000100 00000180 00000005 0000000e 00000001 00000000
// run a records
@120 00000000 00000001 00000002 00000000 00000001 00000002 00000000 00000003
00000002 11223344 00000001 00000005 00000003 00000001 00000005 00000008
00000004 00000004 00000001 00000109
// run b records, ids 2 7 8 13 18 dropped
@134 00000000 00000003 00000001 00000000 00000001 00000000 00000002 00000003
00000003 00000001 00000000 00000005 00000004 00000002 00000002 00000006
00000005 00000005 00000003 00000008 00000006 00000001 00000001 0000000b
00000009 00000004 00000100 0000000c 0000000a 00000001 00000002 00000110
0000000b 00000002 00000001 00000112 0000000c 00000007 00000003 00000113
0000000e 00000001 00000001 00000116 0000000f 00000003 00000002 00000117
00000010 00010000 00000001 00000119 00000011 00000002 00000004 0000011a
